// ==== bip_cpu.f ====
rtl/bip_pkg.sv
rtl/instruction_decoder.sv
rtl/program_counter.sv
rtl/cpu_control.sv
rtl/accumulator_datapath.sv
rtl/data_memory.sv
rtl/program_memory.sv
rtl/bip_cpu.sv
tests/bip_cpu_sva.sv
tests/bip_cpu_tb.sv

// ==== rtl/accumulator_datapath.sv ====
`default_nettype none

module accumulator_datapath (
    input  wire logic                            i_clk,
    input  wire logic                            i_rst,
    input  wire logic                            i_clear,
    input  wire logic                            i_run,
    input  bip_pkg::ctrl_t                       i_ctrl,
    input  wire logic [bip_pkg::NB_OPERAND-1:0]  i_operand,
    input  wire logic [bip_pkg::NB_DATA-1:0]     i_ram_data,
    output logic [bip_pkg::NB_DATA-1:0]          o_acc
);

    logic [bip_pkg::NB_DATA-1:0] imm;
    logic [bip_pkg::NB_DATA-1:0] ram_word;
    logic [bip_pkg::NB_DATA-1:0] alu_b;
    logic [bip_pkg::NB_DATA-1:0] alu_out;
    logic [bip_pkg::NB_DATA-1:0] acc_next;

    // Sign extend the 11-bit immediate
    assign imm = {{(bip_pkg::NB_DATA - bip_pkg::NB_OPERAND){i_operand[bip_pkg::NB_OPERAND-1]}},
                  i_operand};

    assign ram_word = i_ctrl.rd_ram ? i_ram_data : '0;
    assign alu_b    = i_ctrl.sel_b ? imm : ram_word;
    // Wraps at 16 bits in both directions
    assign alu_out  = i_ctrl.op ? (o_acc - alu_b) : (o_acc + alu_b);

    always_comb begin
        case (i_ctrl.sel_a)
            bip_pkg::SELA_RAM: acc_next = ram_word;
            bip_pkg::SELA_IMM: acc_next = imm;
            bip_pkg::SELA_ALU: acc_next = alu_out;
            default:           acc_next = o_acc;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst || i_clear) begin
            o_acc <= '0;
        end
        else if (i_run && i_ctrl.wr_acc) begin
            o_acc <= acc_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bip_cpu.sv ====
`default_nettype none

module bip_cpu (
    input  wire logic                             i_clk,
    input  wire logic                             i_rst,
    input  wire logic                             i_start,
    input  wire logic                             i_prog_we,
    input  wire logic [bip_pkg::PROG_ADDR_W-1:0]  i_prog_addr,
    input  bip_pkg::instr_t                       i_prog_data,
    output logic [bip_pkg::NB_DATA-1:0]           o_acc,
    output logic [bip_pkg::PROG_ADDR_W-1:0]       o_pc,
    output logic                                  o_halted
);

    bip_pkg::instr_t               instr;
    bip_pkg::ctrl_t                ctrl;
    logic                          run;
    logic                          clear;
    logic [bip_pkg::NB_DATA-1:0]   ram_rdata;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch and decode
    ////////////////////////////////////////////////////////////////////////////
    program_memory program_memory_inst (
        .i_clk   (i_clk),
        .i_we    (i_prog_we),
        .i_waddr (i_prog_addr),
        .i_raddr (o_pc),
        .i_wdata (i_prog_data),
        .o_instr (instr)
    );

    instruction_decoder instruction_decoder_inst (
        .i_rst    (i_rst),
        .i_opcode (instr.opcode),
        .o_ctrl   (ctrl)
    );

    cpu_control cpu_control_inst (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (i_start),
        .i_wr_pc  (ctrl.wr_pc),
        .o_run    (run),
        .o_clear  (clear),
        .o_halted (o_halted)
    );

    // PC holds on a halting opcode
    program_counter program_counter_inst (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_clear (clear),
        .i_en    (run & ctrl.wr_pc),
        .o_pc    (o_pc)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////////////////////
    accumulator_datapath accumulator_datapath_inst (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_clear    (clear),
        .i_run      (run),
        .i_ctrl     (ctrl),
        .i_operand  (instr.operand),
        .i_ram_data (ram_rdata),
        .o_acc      (o_acc)
    );

    data_memory data_memory_inst (
        .i_clk   (i_clk),
        .i_we    (run & ctrl.wr_ram),
        .i_addr  (instr.operand[bip_pkg::DATA_ADDR_W-1:0]),
        .i_wdata (o_acc),
        .o_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== rtl/bip_pkg.sv ====
`default_nettype none

package bip_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int NB_OPCODE   = 5;
    localparam int NB_OPERAND  = 11;
    localparam int NB_INSTR    = NB_OPCODE + NB_OPERAND;
    localparam int NB_DATA     = 16;
    localparam int PROG_ADDR_W = 6;
    // Low bits of the operand address data RAM
    localparam int DATA_ADDR_W = 6;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction set
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [NB_OPCODE-1:0] {
        HLT  = 5'd0,
        STO  = 5'd1,
        LD   = 5'd2,
        LDI  = 5'd3,
        ADD  = 5'd4,
        ADDI = 5'd5,
        SUB  = 5'd6,
        SUBI = 5'd7
    } opcode_e;

    // Accumulator source
    typedef enum logic [1:0] {
        SELA_RAM = 2'd0,
        SELA_IMM = 2'd1,
        SELA_ALU = 2'd2
    } sel_a_e;

    typedef struct packed {
        opcode_e                 opcode;
        logic [NB_OPERAND-1:0]   operand;
    } instr_t;

    typedef struct packed {
        logic    wr_pc;
        sel_a_e  sel_a;
        logic    sel_b;
        logic    op;
        logic    wr_acc;
        logic    wr_ram;
        logic    rd_ram;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_control.sv ====
`default_nettype none

module cpu_control (
    input  wire logic  i_clk,
    input  wire logic  i_rst,
    input  wire logic  i_start,
    input  wire logic  i_wr_pc,
    output logic       o_run,
    output logic       o_clear,
    output logic       o_halted
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_HALT = 2'd2
    } state_e;

    state_e state;

    // Start drops back to IDLE for the clear cycle, then RUN
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            state   <= ST_IDLE;
            o_clear <= 1'b0;
        end
        else begin
            o_clear <= 1'b0;
            case (state)
                ST_RUN: begin
                    if (!i_wr_pc) begin
                        state <= ST_HALT;
                    end
                end
                default: begin
                    if (o_clear) begin
                        state <= ST_RUN;
                    end
                    else if (i_start) begin
                        state   <= ST_IDLE;
                        o_clear <= 1'b1;
                    end
                end
            endcase
        end
    end

    assign o_run    = (state == ST_RUN);
    assign o_halted = (state == ST_HALT);

endmodule

`default_nettype wire

// ==== rtl/data_memory.sv ====
`default_nettype none

module data_memory (
    input  wire logic                             i_clk,
    input  wire logic                             i_we,
    input  wire logic [bip_pkg::DATA_ADDR_W-1:0]  i_addr,
    input  wire logic [bip_pkg::NB_DATA-1:0]      i_wdata,
    output logic [bip_pkg::NB_DATA-1:0]           o_rdata
);

    logic [bip_pkg::NB_DATA-1:0] mem [2**bip_pkg::DATA_ADDR_W];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // Read is combinational, same cycle as the instruction
    assign o_rdata = mem[i_addr];

endmodule

`default_nettype wire

// ==== rtl/instruction_decoder.sv ====
`default_nettype none

module instruction_decoder (
    input  wire logic            i_rst,
    input  bip_pkg::opcode_e     i_opcode,
    output bip_pkg::ctrl_t       o_ctrl
);

    always_comb begin
        // Defaults, PC advances unless the opcode stops it
        o_ctrl        = '0;
        o_ctrl.wr_pc  = i_rst;
        o_ctrl.sel_a  = bip_pkg::SELA_RAM;

        case (i_opcode)
            bip_pkg::HLT: begin
                o_ctrl.wr_pc = 1'b0;
            end
            bip_pkg::STO: begin
                o_ctrl.wr_ram = 1'b1;
            end
            bip_pkg::LD: begin
                o_ctrl.wr_acc = 1'b1;
                o_ctrl.rd_ram = 1'b1;
            end
            bip_pkg::LDI: begin
                o_ctrl.sel_a  = bip_pkg::SELA_IMM;
                o_ctrl.wr_acc = 1'b1;
            end
            bip_pkg::ADD: begin
                o_ctrl.sel_a  = bip_pkg::SELA_ALU;
                o_ctrl.wr_acc = 1'b1;
                o_ctrl.rd_ram = 1'b1;
            end
            bip_pkg::ADDI: begin
                o_ctrl.sel_a  = bip_pkg::SELA_ALU;
                o_ctrl.sel_b  = 1'b1;
                o_ctrl.wr_acc = 1'b1;
            end
            bip_pkg::SUB: begin
                o_ctrl.sel_a  = bip_pkg::SELA_ALU;
                o_ctrl.op     = 1'b1;
                o_ctrl.wr_acc = 1'b1;
                o_ctrl.rd_ram = 1'b1;
            end
            bip_pkg::SUBI: begin
                o_ctrl.sel_a  = bip_pkg::SELA_ALU;
                o_ctrl.sel_b  = 1'b1;
                o_ctrl.op     = 1'b1;
                o_ctrl.wr_acc = 1'b1;
            end
            default: begin
                // Undefined opcodes stop like HLT
                o_ctrl.wr_pc = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/program_counter.sv ====
`default_nettype none

module program_counter (
    input  wire logic                            i_clk,
    input  wire logic                            i_rst,
    input  wire logic                            i_clear,
    input  wire logic                            i_en,
    output logic [bip_pkg::PROG_ADDR_W-1:0]      o_pc
);

    // Wraps modulo program memory depth
    always_ff @(posedge i_clk) begin
        if (!i_rst || i_clear) begin
            o_pc <= '0;
        end
        else if (i_en) begin
            o_pc <= o_pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/program_memory.sv ====
`default_nettype none

module program_memory (
    input  wire logic                             i_clk,
    input  wire logic                             i_we,
    input  wire logic [bip_pkg::PROG_ADDR_W-1:0]  i_waddr,
    input  wire logic [bip_pkg::PROG_ADDR_W-1:0]  i_raddr,
    input  bip_pkg::instr_t                       i_wdata,
    output bip_pkg::instr_t                       o_instr
);

    bip_pkg::instr_t mem [2**bip_pkg::PROG_ADDR_W];

    // Load port
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    assign o_instr = mem[i_raddr];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module bip_cpu_tb \
    -f bip_cpu.f -o bip_cpu_sim &&
./obj_dir/bip_cpu_sim | tee /dev/stderr | grep -q "Test passed" &&
echo "Simulation PASS" ||
{ echo "Simulation FAIL"; exit 1; }

// ==== tests/bip_cpu_stim.txt ====
# name, expected o_acc, expected halt o_pc, word count, program words from address 0
# all numbers in hex; opcode in bits 15:11, operand in bits 10:0
ld_sto    0123 04 05 1923 0805 1877 1005 0000
add_sub   fffc 09 0a 1fff 0801 1802 0802 1001 2002 3002 3002 2001 0000
imm_neg   fffe 06 07 1810 2ff0 3c00 2c01 3ffe 3805 0000
hlt_mid   0055 01 04 1855 0000 18aa 0000
undef_08  0321 01 04 1b21 47ff 1911 0000
undef_1f  000f 02 03 280f 0800 f800
restart   000a 02 03 2805 2805 0000
undef_10  0003 03 04 1801 2801 2801 802a

// ==== tests/bip_cpu_sva.sv ====
`default_nettype none

module bip_cpu_sva (
    input  wire logic                             i_clk,
    input  wire logic                             i_rst,
    input  wire logic                             i_run,
    input  wire logic                             i_clear,
    input  wire logic                             i_halted,
    input  wire logic [bip_pkg::DATA_ADDR_W-1:0]  i_ram_addr,
    input  wire logic [bip_pkg::NB_DATA-1:0]      i_ram_rdata,
    input  wire logic [bip_pkg::PROG_ADDR_W-1:0]  i_pc
);

    // Control outputs are low one edge into reset
    reset_quiet: assert property (@(posedge i_clk)
        !i_rst |=> (!i_run && !i_clear && !i_halted))
        else $error("run, clear or halted high during reset");

    pc_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_halted |=> $stable(i_pc))
        else $error("PC moved while halted");

    // Addressed RAM word keeps its value across an edge without run
    ram_quiet: assert property (@(posedge i_clk) disable iff (!i_rst)
        !i_run |=> (!$stable(i_ram_addr) || $stable(i_ram_rdata)))
        else $error("data RAM changed while not running");

    // HALT is entered only from RUN
    halt_from_run: assert property (@(posedge i_clk) disable iff (!i_rst)
        $rose(i_halted) |-> $past(i_run))
        else $error("halted rose without a preceding run cycle");

endmodule

bind bip_cpu bip_cpu_sva bip_cpu_sva_inst (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_run       (run),
    .i_clear     (clear),
    .i_halted    (o_halted),
    .i_ram_addr  (instr.operand[bip_pkg::DATA_ADDR_W-1:0]),
    .i_ram_rdata (ram_rdata),
    .i_pc        (o_pc)
);

`default_nettype wire

// ==== tests/bip_cpu_tb.sv ====
`default_nettype none

module bip_cpu_tb;

    logic                               i_clk;
    logic                               i_rst;
    logic                               i_start;
    logic                               i_prog_we;
    logic [bip_pkg::PROG_ADDR_W-1:0]    i_prog_addr;
    bip_pkg::instr_t                    i_prog_data;
    logic [bip_pkg::NB_DATA-1:0]        o_acc;
    logic [bip_pkg::PROG_ADDR_W-1:0]    o_pc;
    logic                               o_halted;

    logic [bip_pkg::NB_INSTR-1:0]       prog_q [$];
    int                                 pass_count;
    int                                 fail_count;
    bit                                 timed_out;

    bip_cpu bip_cpu_inst (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_prog_we   (i_prog_we),
        .i_prog_addr (i_prog_addr),
        .i_prog_data (i_prog_data),
        .o_acc       (o_acc),
        .o_pc        (o_pc),
        .o_halted    (o_halted)
    );

    always #4 i_clk = ~i_clk;

    ////////////////////////////////////////////////////////////////////////////
    // Program load and start
    ////////////////////////////////////////////////////////////////////////////
    // Queued words go in from address 0
    task automatic load_program();
        for (int i = 0; i < prog_q.size(); i++) begin
            @(posedge i_clk);
            i_prog_we   <= 1'b1;
            i_prog_addr <= i[bip_pkg::PROG_ADDR_W-1:0];
            i_prog_data <= bip_pkg::instr_t'(prog_q[i]);
        end
        @(posedge i_clk);
        i_prog_we <= 1'b0;
    endtask

    // Random idle gap, then a one-cycle start pulse
    task automatic pulse_start();
        int idle;
        idle = $urandom % 4;
        repeat (idle) @(posedge i_clk);
        @(posedge i_clk);
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
    endtask

    task automatic run_program(input string name,
                               input logic [bip_pkg::NB_DATA-1:0] exp_acc,
                               input logic [bip_pkg::PROG_ADDR_W-1:0] exp_pc);
        int                              errors;
        bit                              halted;
        errors = 0;
        halted = 1'b0;
        load_program();
        pulse_start();
        // Halt must come within 200 cycles
        for (int c = 0; c < 200 && !halted; c++) begin
            @(negedge i_clk);
            halted = o_halted;
        end
        if (!halted) begin
            $display("%s: processor did not halt within 200 cycles", name);
            fail_count++;
            timed_out = 1'b1;
        end
        else begin
            if (o_pc !== exp_pc) begin
                $display("[ERROR] %s: o_pc expected %h, got %h", name, exp_pc, o_pc);
                errors++;
            end
            if (o_acc !== exp_acc) begin
                $display("[ERROR] %s: o_acc expected %h, got %h", name, exp_acc, o_acc);
                errors++;
            end
            // Outputs hold while halted
            repeat (10) begin
                @(negedge i_clk);
                if (o_pc !== exp_pc) begin
                    $display("[ERROR] %s: o_pc expected %h, got %h", name, exp_pc, o_pc);
                    errors++;
                end
                if (o_acc !== exp_acc) begin
                    $display("[ERROR] %s: o_acc expected %h, got %h", name, exp_acc, o_acc);
                    errors++;
                end
                if (!o_halted) begin
                    $display("%s: o_halted fell without a new start", name);
                    errors++;
                end
            end
            if (errors == 0) begin
                pass_count++;
                $display("PASS %s", name);
            end
            else begin
                fail_count++;
                $display("FAIL %s with %0d errors", name, errors);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int                              fd;
        int                              rc;
        int                              ch;
        int                              n_words;
        string                           name;
        logic [bip_pkg::NB_DATA-1:0]     exp_acc;
        logic [bip_pkg::PROG_ADDR_W-1:0] exp_pc;
        logic [bip_pkg::NB_INSTR-1:0]    word;

        void'($urandom(32'h5b7e676c));
        i_clk       = 1'b0;
        i_rst       = 1'b0;
        i_start     = 1'b0;
        i_prog_we   = 1'b0;
        i_prog_addr = '0;
        i_prog_data = '0;
        pass_count  = 0;
        fail_count  = 0;
        timed_out   = 1'b0;

        repeat (8) @(posedge i_clk);
        i_rst <= 1'b1;

        fd = $fopen("tests/bip_cpu_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/bip_cpu_stim.txt");
            fail_count++;
        end
        else begin
            while (!timed_out && $fscanf(fd, "%s", name) == 1) begin
                if (name == "#") begin
                    // Comment line, skip to its end
                    ch = 0;
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
                else begin
                    rc = $fscanf(fd, "%h %h %h", exp_acc, exp_pc, n_words);
                    prog_q.delete();
                    for (int i = 0; i < n_words; i++) begin
                        rc += $fscanf(fd, "%h", word);
                        prog_q.push_back(word);
                    end
                    if (rc != 3 + n_words) begin
                        $display("%s: malformed line in the stimulus file", name);
                        fail_count++;
                    end
                    else begin
                        run_program(name, exp_acc, exp_pc);
                    end
                end
            end
            $fclose(fd);
        end

        $display("Summary: %0d passing, %0d failing", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("Test passed");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
